// File: hdl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // on-chip sram
  localparam int SRAM_WORDS = 1024;
  localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;

  // core-local timer words
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'h0200_0004;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // access size as issued by the load/store unit
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_AR    = 3'd1,
    ST_R     = 3'd2,
    ST_AW_W  = 3'd3,
    ST_B     = 3'd4,
    ST_TIMER = 3'd5
  } arb_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    mem_size_e         size;
    logic              write;
  } lsu_req_t;

  // also used for the write address channel
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axil_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

endpackage

`default_nettype wire

// File: hdl/clint_timer.sv
`timescale 1ns/1ns
`default_nettype none

module clint_timer import soc_bus_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              rd_i,
  input  wire logic [ADDR_W-1:0] addr_i,
  output logic [DATA_W-1:0]      rdata_o
);

  logic [63:0] mtime;

  // free-running counter ticking every clock
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime <= '0;
    end
    else
    begin
      mtime <= mtime + 64'd1;
    end
  end

  // bit 2 picks the upper half
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (addr_i[2])
      begin
        rdata_o <= mtime[63:32];
      end
      else
      begin
        rdata_o <= mtime[31:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/axil_sram.sv
`timescale 1ns/1ns
`default_nettype none

module axil_sram import soc_bus_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  // read address and data
  input  wire logic     s_arvalid_i,
  input  wire axil_ar_t s_ar_i,
  output logic          s_arready_o,
  output logic          s_rvalid_o,
  output axil_r_t       s_r_o,
  input  wire logic     s_rready_i,
  // write address, data and response
  input  wire logic     s_awvalid_i,
  input  wire axil_ar_t s_aw_i,
  output logic          s_awready_o,
  input  wire logic     s_wvalid_i,
  input  wire axil_w_t  s_w_i,
  output logic          s_wready_o,
  output logic          s_bvalid_o,
  output axil_b_t       s_b_o,
  input  wire logic     s_bready_i
);

  logic [DATA_W-1:0] mem [SRAM_WORDS];

  logic [DATA_W-1:0]     rdata_q;
  logic                  ar_fire;
  logic [SRAM_IDX_W-1:0] rd_idx;

  logic                  aw_held;
  logic                  w_held;
  logic [ADDR_W-1:0]     aw_addr_q;
  axil_w_t               w_q;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  wr_go;
  logic [ADDR_W-1:0]     wr_addr;
  axil_w_t               wr_beat;
  logic [SRAM_IDX_W-1:0] wr_idx;

  // read channel
  assign s_arready_o = !s_rvalid_o;
  assign ar_fire     = s_arvalid_i && s_arready_o;
  assign rd_idx      = s_ar_i.addr[2 +: SRAM_IDX_W];
  assign s_r_o       = '{data: rdata_q, resp: RESP_OKAY};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      s_rvalid_o <= 1'b0;
    end
    else if (ar_fire)
    begin
      s_rvalid_o <= 1'b1;
    end
    else if (s_rready_i)
    begin
      s_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ar_fire)
    begin
      rdata_q <= mem[rd_idx];
    end
  end

  // write channel takes address and data in either order
  assign s_awready_o = !aw_held && !s_bvalid_o;
  assign s_wready_o  = !w_held && !s_bvalid_o;
  assign aw_fire     = s_awvalid_i && s_awready_o;
  assign w_fire      = s_wvalid_i && s_wready_o;
  assign wr_go       = (aw_held || aw_fire) && (w_held || w_fire);
  assign wr_addr     = aw_held ? aw_addr_q : s_aw_i.addr;
  assign wr_beat     = w_held ? w_q : s_w_i;
  assign wr_idx      = wr_addr[2 +: SRAM_IDX_W];
  assign s_b_o       = '{resp: RESP_OKAY};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      aw_held    <= 1'b0;
      w_held     <= 1'b0;
      s_bvalid_o <= 1'b0;
    end
    else
    begin
      if (wr_go)
      begin
        aw_held    <= 1'b0;
        w_held     <= 1'b0;
        s_bvalid_o <= 1'b1;
      end
      else
      begin
        if (aw_fire)
        begin
          aw_held <= 1'b1;
        end
        if (w_fire)
        begin
          w_held <= 1'b1;
        end
      end
      // no new write is accepted while b is pending
      if (s_bvalid_o && s_bready_i)
      begin
        s_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (aw_fire)
    begin
      aw_addr_q <= s_aw_i.addr;
    end
    if (w_fire)
    begin
      w_q <= s_w_i;
    end
    if (wr_go)
    begin
      for (int i = 0; i < STRB_W; i++)
      begin
        if (wr_beat.strb[i])
        begin
          mem[wr_idx][8*i +: 8] <= wr_beat.data[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter import soc_bus_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  // instruction fetch port
  input  wire logic              ifu_req_valid_i,
  input  wire logic [ADDR_W-1:0] ifu_addr_i,
  output logic                   ifu_rsp_valid_o,
  output logic [DATA_W-1:0]      ifu_rdata_o,
  // load/store port
  input  wire logic              lsu_req_valid_i,
  input  wire lsu_req_t          lsu_req_i,
  output logic                   lsu_rsp_valid_o,
  output logic [DATA_W-1:0]      lsu_rdata_o,
  // axi4-lite master
  output logic                   m_arvalid_o,
  output axil_ar_t               m_ar_o,
  input  wire logic              m_arready_i,
  input  wire logic              m_rvalid_i,
  input  wire axil_r_t           m_r_i,
  output logic                   m_rready_o,
  output logic                   m_awvalid_o,
  output axil_ar_t               m_aw_o,
  input  wire logic              m_awready_i,
  output logic                   m_wvalid_o,
  output axil_w_t                m_w_o,
  input  wire logic              m_wready_i,
  input  wire logic              m_bvalid_i,
  input  wire axil_b_t           m_b_i,
  output logic                   m_bready_o,
  // timer read strobe
  output logic                   timer_rd_o,
  output logic [ADDR_W-1:0]      timer_addr_o,
  input  wire logic [DATA_W-1:0] timer_rdata_i
);

  arb_state_e state;
  lsu_req_t   req_q;
  lsu_req_t   next_req;
  logic       owner_lsu;
  logic       timer_ack;
  logic       rsp_busy;
  logic       take;
  logic       next_timer;
  logic       aw_done;
  logic       w_done;
  logic       rd_done;
  logic [DATA_W-1:0] rd_lane;

  // shift down to bit 0 and zero-extend to the access size
  function automatic logic [DATA_W-1:0] load_lane(input logic [DATA_W-1:0] raw,
                                                  input logic [1:0] lo,
                                                  input mem_size_e size);
    logic [DATA_W-1:0] shifted;
    shifted = raw >> {lo, 3'b000};
    case (size)
      SIZE_BYTE: return {{(DATA_W-8){1'b0}}, shifted[7:0]};
      SIZE_HALF: return {{(DATA_W-16){1'b0}}, shifted[15:0]};
      default:   return shifted;
    endcase
  endfunction

  function automatic logic [STRB_W-1:0] size_strb(input mem_size_e size);
    case (size)
      SIZE_BYTE: return {{(STRB_W-1){1'b0}}, 1'b1};
      SIZE_HALF: return {{(STRB_W-2){1'b0}}, 2'b11};
      default:   return {STRB_W{1'b1}};
    endcase
  endfunction

  // hold off sampling while a response pulse is out
  assign rsp_busy = ifu_rsp_valid_o | lsu_rsp_valid_o;
  assign take = (state == ST_IDLE) && !rsp_busy && (ifu_req_valid_i || lsu_req_valid_i);

  // load/store has priority
  always_comb
  begin
    if (lsu_req_valid_i)
    begin
      next_req = lsu_req_i;
    end
    else
    begin
      next_req = '{addr: ifu_addr_i, wdata: '0, size: SIZE_WORD, write: 1'b0};
    end
  end

  assign next_timer = !next_req.write &&
                      ((next_req.addr[ADDR_W-1:2] == MTIME_LO_ADDR[ADDR_W-1:2]) ||
                       (next_req.addr[ADDR_W-1:2] == MTIME_HI_ADDR[ADDR_W-1:2]));

  // store lanes follow the latched request
  assign m_ar_o = '{addr: req_q.addr};
  assign m_aw_o = '{addr: req_q.addr};
  assign m_w_o  = '{data: req_q.wdata << {req_q.addr[1:0], 3'b000},
                    strb: size_strb(req_q.size) << req_q.addr[1:0]};
  assign timer_addr_o = {req_q.addr[ADDR_W-1:2], 2'b00};

  assign m_rready_o = (state == ST_R);
  assign m_bready_o = (state == ST_B);

  assign aw_done = !m_awvalid_o || m_awready_i;
  assign w_done  = !m_wvalid_o || m_wready_i;

  assign rd_done = ((state == ST_R) && m_rvalid_i) || ((state == ST_TIMER) && timer_ack);
  assign rd_lane = load_lane((state == ST_TIMER) ? timer_rdata_i : m_r_i.data,
                             req_q.addr[1:0], req_q.size);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state           <= ST_IDLE;
      owner_lsu       <= 1'b0;
      m_arvalid_o     <= 1'b0;
      m_awvalid_o     <= 1'b0;
      m_wvalid_o      <= 1'b0;
      timer_rd_o      <= 1'b0;
      timer_ack       <= 1'b0;
      ifu_rsp_valid_o <= 1'b0;
      lsu_rsp_valid_o <= 1'b0;
    end
    else
    begin
      ifu_rsp_valid_o <= 1'b0;
      lsu_rsp_valid_o <= 1'b0;
      timer_rd_o      <= 1'b0;
      // timer data is registered one cycle after the strobe
      timer_ack       <= timer_rd_o;
      case (state)
        ST_IDLE:
        begin
          if (take)
          begin
            owner_lsu <= lsu_req_valid_i;
            if (next_req.write)
            begin
              m_awvalid_o <= 1'b1;
              m_wvalid_o  <= 1'b1;
              state       <= ST_AW_W;
            end
            else if (next_timer)
            begin
              timer_rd_o <= 1'b1;
              state      <= ST_TIMER;
            end
            else
            begin
              m_arvalid_o <= 1'b1;
              state       <= ST_AR;
            end
          end
        end
        ST_AR:
        begin
          if (m_arready_i)
          begin
            m_arvalid_o <= 1'b0;
            state       <= ST_R;
          end
        end
        ST_AW_W:
        begin
          if (m_awready_i)
          begin
            m_awvalid_o <= 1'b0;
          end
          if (m_wready_i)
          begin
            m_wvalid_o <= 1'b0;
          end
          if (aw_done && w_done)
          begin
            state <= ST_B;
          end
        end
        ST_R, ST_TIMER:
        begin
          if (rd_done)
          begin
            ifu_rsp_valid_o <= !owner_lsu;
            lsu_rsp_valid_o <= owner_lsu;
            state           <= ST_IDLE;
          end
        end
        ST_B:
        begin
          // store completion goes to load/store only
          if (m_bvalid_i)
          begin
            lsu_rsp_valid_o <= 1'b1;
            state           <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // request and read data payload
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      req_q <= next_req;
    end
    if (rd_done && owner_lsu)
    begin
      lsu_rdata_o <= rd_lane;
    end
    if (rd_done && !owner_lsu)
    begin
      ifu_rdata_o <= rd_lane;
    end
  end

endmodule

`default_nettype wire

// File: hdl/soc_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top import soc_bus_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              ifu_req_valid_i,
  input  wire logic [ADDR_W-1:0] ifu_addr_i,
  output logic                   ifu_rsp_valid_o,
  output logic [DATA_W-1:0]      ifu_rdata_o,
  input  wire logic              lsu_req_valid_i,
  input  wire lsu_req_t          lsu_req_i,
  output logic                   lsu_rsp_valid_o,
  output logic [DATA_W-1:0]      lsu_rdata_o
);

  // axi4-lite between arbiter and sram
  logic     arvalid;
  logic     arready;
  axil_ar_t ar;
  logic     rvalid;
  logic     rready;
  axil_r_t  r;
  logic     awvalid;
  logic     awready;
  axil_ar_t aw;
  logic     wvalid;
  logic     wready;
  axil_w_t  w;
  logic     bvalid;
  logic     bready;
  axil_b_t  b;

  // timer read port
  logic              timer_rd;
  logic [ADDR_W-1:0] timer_addr;
  logic [DATA_W-1:0] timer_rdata;

  bus_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_valid_i (ifu_req_valid_i),
    .ifu_addr_i      (ifu_addr_i),
    .ifu_rsp_valid_o (ifu_rsp_valid_o),
    .ifu_rdata_o     (ifu_rdata_o),
    .lsu_req_valid_i (lsu_req_valid_i),
    .lsu_req_i       (lsu_req_i),
    .lsu_rsp_valid_o (lsu_rsp_valid_o),
    .lsu_rdata_o     (lsu_rdata_o),
    .m_arvalid_o     (arvalid),
    .m_ar_o          (ar),
    .m_arready_i     (arready),
    .m_rvalid_i      (rvalid),
    .m_r_i           (r),
    .m_rready_o      (rready),
    .m_awvalid_o     (awvalid),
    .m_aw_o          (aw),
    .m_awready_i     (awready),
    .m_wvalid_o      (wvalid),
    .m_w_o           (w),
    .m_wready_i      (wready),
    .m_bvalid_i      (bvalid),
    .m_b_i           (b),
    .m_bready_o      (bready),
    .timer_rd_o      (timer_rd),
    .timer_addr_o    (timer_addr),
    .timer_rdata_i   (timer_rdata)
  );

  clint_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .rd_i    (timer_rd),
    .addr_i  (timer_addr),
    .rdata_o (timer_rdata)
  );

  axil_sram u_sram (
    .clk         (clk),
    .rst         (rst),
    .s_arvalid_i (arvalid),
    .s_ar_i      (ar),
    .s_arready_o (arready),
    .s_rvalid_o  (rvalid),
    .s_r_o       (r),
    .s_rready_i  (rready),
    .s_awvalid_i (awvalid),
    .s_aw_i      (aw),
    .s_awready_o (awready),
    .s_wvalid_i  (wvalid),
    .s_w_i       (w),
    .s_wready_o  (wready),
    .s_bvalid_o  (bvalid),
    .s_b_o       (b),
    .s_bready_i  (bready)
  );

endmodule

`default_nettype wire

// File: tests/soc_bus_assert.sv
`timescale 1ns/1ns
`default_nettype none

module soc_bus_assert import soc_bus_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     arvalid_i,
  input  wire logic     arready_i,
  input  wire axil_ar_t ar_i,
  input  wire logic     awvalid_i,
  input  wire logic     awready_i,
  input  wire axil_ar_t aw_i,
  input  wire logic     wvalid_i,
  input  wire logic     wready_i,
  input  wire axil_w_t  w_i,
  input  wire logic     rvalid_i,
  input  wire axil_r_t  r_i,
  input  wire logic     bvalid_i,
  input  wire axil_b_t  b_i,
  input  wire logic     ifu_rsp_valid_i,
  input  wire logic     lsu_rsp_valid_i
);

  // number of assertion failures so far
  int fail_count = 0;

  // valid and payload held until the handshake edge
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
    else
    begin
      $error("arvalid or ar payload changed before handshake");
      fail_count++;
    end

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
    else
    begin
      $error("awvalid or aw payload changed before handshake");
      fail_count++;
    end

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
    else
    begin
      $error("wvalid or w payload changed before handshake");
      fail_count++;
    end

  // slave always answers okay
  r_okay: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> r_i.resp == RESP_OKAY)
    else
    begin
      $error("rresp not okay");
      fail_count++;
    end

  b_okay: assert property (@(posedge clk) disable iff (rst)
    bvalid_i |-> b_i.resp == RESP_OKAY)
    else
    begin
      $error("bresp not okay");
      fail_count++;
    end

  ifu_pulse: assert property (@(posedge clk) disable iff (rst)
    ifu_rsp_valid_i |=> !ifu_rsp_valid_i)
    else
    begin
      $error("fetch response valid longer than one cycle");
      fail_count++;
    end

  lsu_pulse: assert property (@(posedge clk) disable iff (rst)
    lsu_rsp_valid_i |=> !lsu_rsp_valid_i)
    else
    begin
      $error("load/store response valid longer than one cycle");
      fail_count++;
    end

  // one transaction at a time
  rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(arvalid_i && awvalid_i))
    else
    begin
      $error("arvalid and awvalid high together");
      fail_count++;
    end

endmodule

bind bus_arbiter soc_bus_assert u_assert (
  .clk             (clk),
  .rst             (rst),
  .arvalid_i       (m_arvalid_o),
  .arready_i       (m_arready_i),
  .ar_i            (m_ar_o),
  .awvalid_i       (m_awvalid_o),
  .awready_i       (m_awready_i),
  .aw_i            (m_aw_o),
  .wvalid_i        (m_wvalid_o),
  .wready_i        (m_wready_i),
  .w_i             (m_w_o),
  .rvalid_i        (m_rvalid_i),
  .r_i             (m_r_i),
  .bvalid_i        (m_bvalid_i),
  .b_i             (m_b_i),
  .ifu_rsp_valid_i (ifu_rsp_valid_o),
  .lsu_rsp_valid_i (lsu_rsp_valid_o)
);

`default_nettype wire

// File: tests/tb_soc_bus.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc_bus import soc_bus_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES = 20;
  // transactions issued by tests 2 to 6
  localparam int NUM_TXNS = 48 + 64 + 16 + 3 + 200;
  localparam int WATCHDOG_CYCLES = NUM_TXNS * 50 + RESET_CYCLES + IDLE_CYCLES;

  logic              clk;
  logic              rst;
  logic              ifu_req_valid;
  logic [ADDR_W-1:0] ifu_addr;
  logic              ifu_rsp_valid;
  logic [DATA_W-1:0] ifu_rdata;
  logic              lsu_req_valid;
  lsu_req_t          lsu_req;
  logic              lsu_rsp_valid;
  logic [DATA_W-1:0] lsu_rdata;

  // reference copy of the sram
  logic [DATA_W-1:0] model_mem [SRAM_WORDS];
  bit                written [SRAM_WORDS];
  int                written_q[$];

  logic [15:0] lfsr;
  int          pass_count;
  int          error_count;
  int          test_errors;

  soc_bus_top u_dut (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_valid_i (ifu_req_valid),
    .ifu_addr_i      (ifu_addr),
    .ifu_rsp_valid_o (ifu_rsp_valid),
    .ifu_rdata_o     (ifu_rdata),
    .lsu_req_valid_i (lsu_req_valid),
    .lsu_req_i       (lsu_req),
    .lsu_rsp_valid_o (lsu_rsp_valid),
    .lsu_rdata_o     (lsu_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: a response never came after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic mem_size_e rand_size();
    logic [1:0] s;
    s = rand_bits(2);
    if (s == 2'd0)
    begin
      return SIZE_BYTE;
    end
    return (s == 2'd1) ? SIZE_HALF : SIZE_WORD;
  endfunction

  // bytes anywhere, halfwords aligned, words at offset 0
  function automatic logic [1:0] rand_offset(input mem_size_e size);
    case (size)
      SIZE_BYTE: return rand_bits(2);
      SIZE_HALF: return {rand_bits(1) != 0, 1'b0};
      default:   return 2'd0;
    endcase
  endfunction

  function automatic int nbytes(input mem_size_e size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] sram_addr(input int idx, input logic [1:0] off);
    return SRAM_BASE + idx * 4 + off;
  endfunction

  function automatic int pick_written();
    return written_q[rand_bits(16) % written_q.size()];
  endfunction

  // addressed bytes moved to bit 0 and zero-extended
  function automatic logic [DATA_W-1:0] model_load(input logic [ADDR_W-1:0] addr,
                                                   input mem_size_e size);
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] v;
    word = model_mem[addr[2 +: SRAM_IDX_W]];
    v = '0;
    for (int b = 0; b < nbytes(size); b++)
    begin
      v[8*b +: 8] = word[8*(addr[1:0] + b) +: 8];
    end
    return v;
  endfunction

  task automatic model_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input mem_size_e size);
    int idx;
    idx = addr[2 +: SRAM_IDX_W];
    for (int b = 0; b < nbytes(size); b++)
    begin
      model_mem[idx][8*(addr[1:0] + b) +: 8] = wdata[8*b +: 8];
    end
    if (!written[idx])
    begin
      written[idx] = 1'b1;
      written_q.push_back(idx);
    end
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    if (actual !== expected)
    begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      error_count++;
    end
    else
    begin
      pass_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR time=%0t %s", $time, what);
    error_count++;
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // hold the request until the response pulse
  task automatic lsu_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input mem_size_e size, input logic write,
                            output logic [DATA_W-1:0] rdata);
    @(negedge clk);
    lsu_req = '{addr: addr, wdata: wdata, size: size, write: write};
    lsu_req_valid = 1'b1;
    do
    begin
      @(negedge clk);
      if (ifu_rsp_valid)
      begin
        report_failure("fetch response without a fetch request");
      end
    end
    while (!lsu_rsp_valid);
    rdata = lsu_rdata;
    lsu_req_valid = 1'b0;
  endtask

  task automatic store_and_model(input logic [ADDR_W-1:0] addr,
                                 input logic [DATA_W-1:0] wdata, input mem_size_e size);
    logic [DATA_W-1:0] unused;
    lsu_access(addr, wdata, size, 1'b1, unused);
    model_store(addr, wdata, size);
  endtask

  task automatic load_and_check(input logic [ADDR_W-1:0] addr, input mem_size_e size);
    logic [DATA_W-1:0] rd;
    lsu_access(addr, '0, size, 1'b0, rd);
    check_value("lsu_rdata_o", model_load(addr, size), rd);
  endtask

  task automatic fetch_and_check(input logic [ADDR_W-1:0] addr);
    @(negedge clk);
    ifu_addr = addr;
    ifu_req_valid = 1'b1;
    do
    begin
      @(negedge clk);
      if (lsu_rsp_valid)
      begin
        report_failure("load/store response without a load/store request");
      end
    end
    while (!ifu_rsp_valid);
    check_value("ifu_rdata_o", model_load(addr, SIZE_WORD), ifu_rdata);
    ifu_req_valid = 1'b0;
  endtask

  initial
  begin
    logic [ADDR_W-1:0] addr_v;
    logic [ADDR_W-1:0] fetch_v;
    logic [DATA_W-1:0] data_v;
    logic [DATA_W-1:0] t0;
    logic [DATA_W-1:0] t1;
    int                idx;
    int                kind;
    int                idx_list[16];
    mem_size_e         size;
    logic              lsu_seen;
    logic              ifu_seen;

    rst = 1'b1;
    ifu_req_valid = 1'b0;
    ifu_addr = '0;
    lsu_req_valid = 1'b0;
    lsu_req = '0;
    lfsr = 16'd48;
    pass_count = 0;
    error_count = 0;
    test_errors = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (IDLE_CYCLES)
    begin
      @(negedge clk);
      check_value("ifu_rsp_valid_o", '0, ifu_rsp_valid);
      check_value("lsu_rsp_valid_o", '0, lsu_rsp_valid);
    end
    finish_test(1, "idle after reset");

    for (int i = 0; i < 16; i++)
    begin
      idx_list[i] = rand_bits(SRAM_IDX_W);
      data_v = rand_bits(32);
      store_and_model(sram_addr(idx_list[i], 2'd0), data_v, SIZE_WORD);
    end
    for (int i = 0; i < 16; i++)
    begin
      load_and_check(sram_addr(idx_list[i], 2'd0), SIZE_WORD);
      fetch_and_check(sram_addr(idx_list[i], 2'd0));
    end
    finish_test(2, "word store and load");

    for (int i = 0; i < 8; i++)
    begin
      idx = rand_bits(SRAM_IDX_W);
      data_v = rand_bits(32);
      store_and_model(sram_addr(idx, 2'd0), data_v, SIZE_WORD);
      for (int j = 0; j < 3; j++)
      begin
        size = (rand_bits(1) != 0) ? SIZE_HALF : SIZE_BYTE;
        addr_v = sram_addr(idx, rand_offset(size));
        data_v = rand_bits(32);
        store_and_model(addr_v, data_v, size);
        load_and_check(addr_v, size);
      end
      load_and_check(sram_addr(idx, 2'd0), SIZE_WORD);
    end
    finish_test(3, "subword merge and load");

    // both requesters raised on the same edge
    for (int i = 0; i < 8; i++)
    begin
      addr_v = sram_addr(pick_written(), 2'd0);
      fetch_v = sram_addr(pick_written(), 2'd0);
      @(negedge clk);
      lsu_req = '{addr: addr_v, wdata: '0, size: SIZE_WORD, write: 1'b0};
      lsu_req_valid = 1'b1;
      ifu_addr = fetch_v;
      ifu_req_valid = 1'b1;
      lsu_seen = 1'b0;
      ifu_seen = 1'b0;
      while (!(lsu_seen && ifu_seen))
      begin
        @(negedge clk);
        if (lsu_rsp_valid)
        begin
          check_value("lsu_rdata_o", model_load(addr_v, SIZE_WORD), lsu_rdata);
          lsu_seen = 1'b1;
          lsu_req_valid = 1'b0;
        end
        if (ifu_rsp_valid)
        begin
          if (!lsu_seen)
          begin
            report_failure("fetch was answered before the load/store request");
          end
          check_value("ifu_rdata_o", model_load(fetch_v, SIZE_WORD), ifu_rdata);
          ifu_seen = 1'b1;
          ifu_req_valid = 1'b0;
        end
      end
    end
    finish_test(4, "load/store priority");

    lsu_access(MTIME_HI_ADDR, '0, SIZE_WORD, 1'b0, t0);
    check_value("lsu_rdata_o", '0, t0);
    lsu_access(MTIME_LO_ADDR, '0, SIZE_WORD, 1'b0, t0);
    lsu_access(MTIME_LO_ADDR, '0, SIZE_WORD, 1'b0, t1);
    if ((t1 > t0) !== 1'b1)
    begin
      report_failure("mtime did not increase between two loads");
    end
    finish_test(5, "timer reads");

    for (int i = 0; i < 200; i++)
    begin
      repeat (rand_bits(2)) @(negedge clk);
      kind = rand_bits(2);
      if (kind == 0)
      begin
        fetch_and_check(sram_addr(pick_written(), 2'd0));
      end
      else if (kind == 1)
      begin
        idx = pick_written();
        size = rand_size();
        load_and_check(sram_addr(idx, rand_offset(size)), size);
      end
      else
      begin
        // a fresh word gets a full store first
        idx = rand_bits(SRAM_IDX_W);
        size = written[idx] ? rand_size() : SIZE_WORD;
        addr_v = sram_addr(idx, rand_offset(size));
        data_v = rand_bits(32);
        store_and_model(addr_v, data_v, size);
      end
    end
    finish_test(6, "random mixed traffic");

    if (u_dut.u_arbiter.u_assert.fail_count != 0)
    begin
      report_failure("bound bus assertions failed during the run");
    end

    $display("summary: %0d checks passed, %0d errors", pass_count, error_count);
    if (error_count == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/soc_bus_pkg.sv
hdl/clint_timer.sv
hdl/axil_sram.sv
hdl/bus_arbiter.sv
hdl/soc_bus_top.sv
tests/soc_bus_assert.sv
tests/tb_soc_bus.sv
